// File: riscv_data_cache.f
source/riscv_dcache_pkg.sv
source/riscv_dcache_mem_if.sv
source/riscv_dcache_tag.sv
source/riscv_dcache_data.sv
source/riscv_dcache_fsm.sv
source/dram.sv
source/riscv_data_cache.sv
testbench/riscv_data_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the data cache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f riscv_data_cache.f \
  --top-module riscv_data_cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build did not succeed"
  exit 1
fi

output=$(./obj_dir/Vriscv_data_cache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

// File: source/dram.sv
`timescale 1ns/1ps
`default_nettype none

module dram import riscv_dcache_pkg::*; (
  input  wire logic       i_riscv_dcache_clk,
  input  wire logic       i_rst_n,
  riscv_dcache_mem_if.mem bus
);

  line_t mem_q [2**LADDR_W] = '{default: '0};

  logic [$clog2(MEM_LAT+1)-1:0] lat_cnt;
  logic                         ready_q;
  line_t                        rdata_q;

  //////////////////////////////////////////////////////////////////////
  // latency counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_riscv_dcache_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lat_cnt <= '0;
      ready_q <= 1'b0;
    end else if (ready_q) begin
      ready_q <= 1'b0;  // single-cycle pulse
      lat_cnt <= '0;
    end else if (bus.req) begin
      if (int'(lat_cnt) == MEM_LAT - 1) begin
        ready_q <= 1'b1;
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

  // transfer happens on the edge that raises ready
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (!ready_q && bus.req && int'(lat_cnt) == MEM_LAT - 1) begin
      if (bus.we) begin
        mem_q[bus.addr] <= bus.wdata;
      end else begin
        rdata_q <= mem_q[bus.addr];  // held until the next read
      end
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  a_ready_needs_req : assert property (
    @(posedge i_riscv_dcache_clk) disable iff (!i_rst_n)
    $rose(bus.ready) |-> bus.req
  );

endmodule

`default_nettype wire

// File: source/riscv_data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_data_cache import riscv_dcache_pkg::*; (
  input  wire logic       i_riscv_dcache_clk,
  input  wire logic       i_rst_n,
  input  wire logic       i_globstall,
  input  wire logic       i_cpu_wren,
  input  wire logic       i_cpu_rden,
  input  wire store_src_t i_store_src,
  input  wire addr_t      i_phys_addr,
  input  wire word_t      i_cpu_data,
  output word_t           o_cpu_data,
  output logic            o_stall
);

  tag_t  tag;
  idx_t  index;
  off_t  byte_offset;

  logic  tag_hit;
  logic  tag_dirty;
  tag_t  tag_old;

  logic  fsm_cache_wren;
  logic  fsm_fill;
  logic  fsm_set_dirty;
  logic  fsm_replace_tag;
  logic  wback_done;
  line_t cache_line;

  riscv_dcache_mem_if mem_bus ();

  //////////////////////////////////////////////////////////////////////
  // address split and cpu word select
  //////////////////////////////////////////////////////////////////////
  assign {tag, index, byte_offset} = i_phys_addr;

  assign o_cpu_data = i_phys_addr[3] ? cache_line[LINE_W-1:WORD_W] : cache_line[WORD_W-1:0];

  assign mem_bus.wdata = cache_line;  // victim line straight from the array
  assign wback_done    = mem_bus.req && mem_bus.we && mem_bus.ready;

  riscv_dcache_tag u_dcache_tag (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_index            (index),
    .i_tag              (tag),
    .i_set_dirty        (fsm_set_dirty),
    .i_clr_dirty        (wback_done),
    .i_replace_tag      (fsm_replace_tag),
    .o_hit              (tag_hit),
    .o_dirty            (tag_dirty),
    .o_tag_old          (tag_old)
  );

  riscv_dcache_data u_dcache_data (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_wren             (fsm_cache_wren),
    .i_fill             (fsm_fill),
    .i_index            (index),
    .i_offset           (byte_offset),
    .i_store_src        (i_store_src),
    .i_cpu_data         (i_cpu_data),
    .i_fill_line        (mem_bus.rdata),
    .o_line             (cache_line)
  );

  riscv_dcache_fsm u_dcache_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .i_rden             (i_cpu_rden),
    .i_wren             (i_cpu_wren),
    .i_globstall        (i_globstall),
    .i_hit              (tag_hit),
    .i_dirty            (tag_dirty),
    .i_index            (index),
    .i_tag              (tag),
    .i_tag_old          (tag_old),
    .mem                (mem_bus.ctrl),
    .o_cache_wren       (fsm_cache_wren),
    .o_fill             (fsm_fill),
    .o_set_dirty        (fsm_set_dirty),
    .o_replace_tag      (fsm_replace_tag),
    .o_stall            (o_stall)
  );

  dram u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst_n            (i_rst_n),
    .bus                (mem_bus.mem)
  );

endmodule

`default_nettype wire

// File: source/riscv_dcache_data.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_data import riscv_dcache_pkg::*; (
  input  wire logic       i_riscv_dcache_clk,
  input  wire logic       i_wren,
  input  wire logic       i_fill,
  input  wire idx_t       i_index,
  input  wire off_t       i_offset,
  input  wire store_src_t i_store_src,
  input  wire word_t      i_cpu_data,
  input  wire line_t      i_fill_line,
  output line_t           o_line
);

  line_t line_q [CACHE_DEPTH];

  line_t            size_mask;  // low bytes covered by the store
  line_t            wr_mask;
  line_t            wr_data;
  line_t            merged;
  logic [OFF_W+2:0] bit_shift;

  //////////////////////////////////////////////////////////////////////
  // store merge
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (i_store_src)
      2'b00:   size_mask = line_t'(8'hff);
      2'b01:   size_mask = line_t'(16'hffff);
      2'b10:   size_mask = line_t'(32'hffff_ffff);
      default: size_mask = line_t'({WORD_W{1'b1}});
    endcase
  end

  assign bit_shift = {i_offset, 3'b000};  // byte offset in bits
  assign wr_mask   = size_mask << bit_shift;
  assign wr_data   = line_t'(i_cpu_data) << bit_shift;
  assign merged    = (line_q[i_index] & ~wr_mask) | (wr_data & wr_mask);

  //////////////////////////////////////////////////////////////////////
  // line array
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_fill) begin
      line_q[i_index] <= i_fill_line;  // whole line from memory
    end else if (i_wren) begin
      line_q[i_index] <= merged;
    end
  end

  assign o_line = line_q[i_index];  // async read, also feeds write-back

  // a store never lands in the same cycle as a refill
  a_no_store_during_fill : assert property (
    @(posedge i_riscv_dcache_clk) !(i_wren && i_fill)
  );

endmodule

`default_nettype wire

// File: source/riscv_dcache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_fsm import riscv_dcache_pkg::*; (
  input  wire logic          i_riscv_dcache_clk,
  input  wire logic          i_rst_n,
  input  wire logic          i_rden,
  input  wire logic          i_wren,
  input  wire logic          i_globstall,
  input  wire logic          i_hit,
  input  wire logic          i_dirty,
  input  wire idx_t          i_index,
  input  wire tag_t          i_tag,
  input  wire tag_t          i_tag_old,
  riscv_dcache_mem_if.ctrl   mem,
  output logic               o_cache_wren,
  output logic               o_fill,
  output logic               o_set_dirty,
  output logic               o_replace_tag,
  output logic               o_stall
);

  dc_state_t state_q;
  dc_state_t state_d;
  logic      ack_q;  // ready seen last cycle so req drops for one cycle
  logic      miss;

  assign miss = (i_rden || i_wren) && !i_hit;

  always_ff @(posedge i_riscv_dcache_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= mem.ready;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d       = state_q;
    o_cache_wren  = 1'b0;
    o_set_dirty   = 1'b0;
    o_fill        = 1'b0;
    o_replace_tag = 1'b0;
    mem.req       = 1'b0;
    mem.we        = 1'b0;
    mem.addr      = {i_tag, i_index};  // new line address by default

    case (state_q)
      S_IDLE: begin
        if (i_wren && i_hit && !i_globstall) begin
          o_cache_wren = 1'b1;
          o_set_dirty  = 1'b1;
        end
        if (miss && !i_globstall) begin
          state_d = i_dirty ? S_WBACK : S_REFILL;
        end
      end
      S_WBACK: begin
        mem.req  = !ack_q;
        mem.we   = 1'b1;
        mem.addr = {i_tag_old, i_index};  // victim line
        // a started transfer finishes even under global stall
        if (mem.ready) begin
          state_d = S_REFILL;
        end
      end
      S_REFILL: begin
        mem.req = !ack_q;
        if (mem.ready) begin
          state_d = S_FILL;
        end
      end
      S_FILL: begin
        if (!i_globstall) begin
          o_fill        = 1'b1;
          o_replace_tag = 1'b1;
          state_d       = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  assign o_stall = (state_q != S_IDLE) || miss;

  // request fields hold steady until memory answers
  a_req_held_until_ready : assert property (
    @(posedge i_riscv_dcache_clk) disable iff (!i_rst_n)
    (mem.req && !mem.ready) |=> (mem.req && $stable(mem.we) && $stable(mem.addr))
  );

endmodule

`default_nettype wire

// File: source/riscv_dcache_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// line-wide bus between the cache and the backing memory
interface riscv_dcache_mem_if import riscv_dcache_pkg::*; ();

  logic   req;    // valid, held until ready
  logic   we;     // write-back when high
  laddr_t addr;
  line_t  wdata;
  logic   ready;  // one-cycle pulse
  line_t  rdata;

  modport ctrl (output req, output we, output addr, input ready);

  modport mem (input req, input we, input addr, input wdata,
               output ready, output rdata);

  modport src (output wdata, input rdata);

endinterface

`default_nettype wire

// File: source/riscv_dcache_pkg.sv
`default_nettype none

package riscv_dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////
  localparam int LINE_W      = 128;                    // bits per line
  localparam int WORD_W      = 64;                     // cpu data width
  localparam int CACHE_DEPTH = 16;                     // number of lines
  localparam int ADDR_W      = 12;                     // byte address, 4 KiB
  localparam int OFF_W       = 4;
  localparam int IDX_W       = 4;
  localparam int TAG_W       = ADDR_W - IDX_W - OFF_W;
  localparam int LADDR_W     = TAG_W + IDX_W;          // memory line address
  localparam int MEM_LAT     = 4;                      // req to ready, in cycles

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [IDX_W-1:0]   idx_t;
  typedef logic [OFF_W-1:0]   off_t;
  typedef logic [LADDR_W-1:0] laddr_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [WORD_W-1:0]  word_t;

  // 00 byte, 01 half, 10 word, 11 double
  typedef logic [1:0] store_src_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WBACK,   // victim line going out
    S_REFILL,  // new line coming in
    S_FILL     // write refill into the arrays
  } dc_state_t;

endpackage

`default_nettype wire

// File: source/riscv_dcache_tag.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_tag import riscv_dcache_pkg::*; (
  input  wire logic i_riscv_dcache_clk,
  input  wire logic i_rst_n,
  input  wire idx_t i_index,
  input  wire tag_t i_tag,
  input  wire logic i_set_dirty,
  input  wire logic i_clr_dirty,
  input  wire logic i_replace_tag,
  output logic      o_hit,
  output logic      o_dirty,
  output tag_t      o_tag_old
);

  tag_t                   tag_q [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid_q;
  logic [CACHE_DEPTH-1:0] dirty_q;

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_replace_tag) begin
      tag_q[i_index] <= i_tag;
    end
  end

  always_ff @(posedge i_riscv_dcache_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (i_replace_tag) begin
        valid_q[i_index] <= 1'b1;
        dirty_q[i_index] <= 1'b0;  // fresh line from memory
      end else if (i_set_dirty) begin
        dirty_q[i_index] <= 1'b1;
      end else if (i_clr_dirty) begin
        dirty_q[i_index] <= 1'b0;  // write-back done
      end
    end
  end

  assign o_hit     = valid_q[i_index] && (tag_q[i_index] == i_tag);
  assign o_dirty   = valid_q[i_index] && dirty_q[i_index];
  assign o_tag_old = tag_q[i_index];

  // refill and store commit come from different controller states
  a_no_replace_and_store : assert property (
    @(posedge i_riscv_dcache_clk) disable iff (!i_rst_n)
    !(i_replace_tag && i_set_dirty)
  );

endmodule

`default_nettype wire

// File: testbench/riscv_data_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_data_cache_tb import riscv_dcache_pkg::*; ();

  localparam int STALL_TIMEOUT = 40;  // dirty miss takes about 13 cycles

  logic       clk;
  logic       rst_n;
  logic       globstall;
  logic       cpu_wren;
  logic       cpu_rden;
  store_src_t store_src;
  addr_t      phys_addr;
  word_t      cpu_data;
  word_t      rd_data;
  logic       stall;

  logic [7:0] shadow [2**ADDR_W];  // byte image of what memory should hold
  integer     seed;
  int         err_cnt;
  int         test_cnt;
  int         test_err_base;
  word_t      load_val;
  logic       first_stall;  // o_stall in the request cycle

  riscv_data_cache dut_i (
    .i_riscv_dcache_clk (clk),
    .i_rst_n            (rst_n),
    .i_globstall        (globstall),
    .i_cpu_wren         (cpu_wren),
    .i_cpu_rden         (cpu_rden),
    .i_store_src        (store_src),
    .i_phys_addr        (phys_addr),
    .i_cpu_data         (cpu_data),
    .o_cpu_data         (rd_data),
    .o_stall            (stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  function automatic word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // aligned doubleword that holds addr
  function automatic word_t shadow_word(input addr_t addr);
    word_t w;
    addr_t base;
    int    i;
    base = {addr[ADDR_W-1:3], 3'b000};
    for (i = 0; i < 8; i++) w[8*i +: 8] = shadow[base + addr_t'(i)];
    return w;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_stall(input logic exp);
    assert (first_stall === exp) else begin
      $display("Error at %0t ns: o_stall = %b, expected %b", $time, first_stall, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_stall_low();
    int cycles;
    cycles = 0;
    while (stall !== 1'b0 && cycles < STALL_TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (stall !== 1'b0) begin
      $display("timeout: o_stall did not fall within %0d cycles at %0t ns", STALL_TIMEOUT, $time);
      $display("tests failed");
      $finish;
    end
  endtask

  // one load or store held until the cache stops stalling
  task automatic cpu_access(input logic wr, input addr_t addr, input store_src_t size,
                            input word_t data, input logic gstall);
    int i;
    @(negedge clk);
    cpu_rden  = !wr;
    cpu_wren  = wr;
    phys_addr = addr;
    store_src = size;
    cpu_data  = data;
    globstall = gstall;
    #1;
    first_stall = stall;
    wait_stall_low();
    load_val = rd_data;
    if (wr && !gstall) begin  // commits at the next rising edge
      for (i = 0; i < (1 << size); i++) shadow[addr + addr_t'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic load_and_check(input addr_t addr, input logic exp_stall);
    cpu_access(1'b0, addr, 2'b11, '0, 1'b0);
    check_stall(exp_stall);
    check_word("o_cpu_data", load_val, shadow_word(addr));
  endtask

  task automatic release_bus();
    @(negedge clk);
    cpu_rden  = 1'b0;
    cpu_wren  = 1'b0;
    globstall = 1'b0;
  endtask

  task automatic begin_test();
    test_err_base = err_cnt;
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) $display("test %0d %s: ok", test_cnt, name);
    else $display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - test_err_base);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    int         a;
    int         n;
    logic [31:0] r;
    off_t       offs;
    store_src_t sz;
    seed      = 47;
    err_cnt   = 0;
    test_cnt  = 0;
    rst_n     = 1'b0;
    globstall = 1'b0;
    cpu_wren  = 1'b0;
    cpu_rden  = 1'b0;
    store_src = 2'b11;
    phys_addr = '0;
    cpu_data  = '0;
    for (a = 0; a < 2**ADDR_W; a++) shadow[a] = 8'h00;  // memory starts at zero
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test();
    cpu_access(1'b0, 12'h3a0, 2'b11, '0, 1'b0);
    check_stall(1'b1);  // cold cache
    check_word("o_cpu_data", load_val, '0);
    release_bus();
    report_test("miss after reset");

    begin_test();
    load_and_check(12'h3a8, 1'b0);  // other half of the same line
    release_bus();
    report_test("hit on loaded line");

    begin_test();
    cpu_access(1'b1, 12'h3a8, 2'b11, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3a0, 2'b11, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3a4, 2'b10, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3a2, 2'b01, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3a1, 2'b00, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3ac, 2'b01, rand_word(), 1'b0);
    cpu_access(1'b1, 12'h3af, 2'b00, rand_word(), 1'b0);
    load_and_check(12'h3a0, 1'b0);
    load_and_check(12'h3a8, 1'b0);
    release_bus();
    report_test("store size merge");

    begin_test();
    cpu_access(1'b1, 12'h128, 2'b11, rand_word(), 1'b0);
    load_and_check(12'h528, 1'b1);  // same index so the dirty line is evicted
    load_and_check(12'h128, 1'b1);  // back from memory
    release_bus();
    report_test("dirty eviction");

    begin_test();
    load_and_check(12'h128, 1'b0);
    cpu_access(1'b1, 12'h128, 2'b10, rand_word(), 1'b1);  // must not commit
    release_bus();
    load_and_check(12'h128, 1'b0);
    release_bus();
    report_test("store under global stall");

    ////////////////////////////////////////////////////////////////////
    // random mix over two indexes and four tags
    ////////////////////////////////////////////////////////////////////
    begin_test();
    for (n = 0; n < 60; n++) begin
      r    = $random(seed);
      sz   = r[9:8];
      offs = r[6:3] & ~off_t'((1 << sz) - 1);  // natural alignment
      if (r[10]) begin
        cpu_access(1'b1, {tag_t'(r[1:0]), idx_t'(r[2]), offs}, sz, rand_word(), 1'b0);
      end else begin
        cpu_access(1'b0, {tag_t'(r[1:0]), idx_t'(r[2]), offs}, 2'b11, '0, 1'b0);
        check_word("o_cpu_data", load_val, shadow_word({tag_t'(r[1:0]), idx_t'(r[2]), offs}));
      end
    end
    release_bus();
    report_test("random conflicting traffic");

    $display("%0d tests run, %0d check errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
